// File: flist.f
source/torus_route_pkg.sv
source/route_dir_if.sv
source/torus_dir_compare.sv
source/torus_port_select.sv
source/torus_route_unit.sv
testbench/tb_torus_route.sv

// File: source/route_dir_if.sv
`default_nettype none

interface route_dir_if;

    logic                        valid;
    logic                        ready;
    torus_route_pkg::route_alg_e alg;    // algorithm travels with the flags
    logic                        x_plus;
    logic                        x_min;
    logic                        y_plus;
    logic                        y_min;
    logic                        same_x;
    logic                        same_y;

    modport producer (
        output valid, alg,
        output x_plus, x_min, y_plus, y_min, same_x, same_y,
        input  ready
    );

    modport consumer (
        input  valid, alg,
        input  x_plus, x_min, y_plus, y_min, same_x, same_y,
        output ready
    );

endinterface

`default_nettype wire

// File: source/torus_dir_compare.sv
`default_nettype none

module torus_dir_compare #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        req_valid,
    output logic                             req_ready,
    input  wire torus_route_pkg::route_alg_e req_alg,
    input  wire logic [XW-1:0]               current_x,
    input  wire logic [YW-1:0]               current_y,
    input  wire logic [XW-1:0]               dest_x,
    input  wire logic [YW-1:0]               dest_y,
    route_dir_if.producer                    dir
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    // shortest direction around one ring of n nodes
    // result packed as {plus, min, same}
    function automatic logic [2:0] torus_dir(input int cur, input int dst, input int n);
        int   diff;
        logic plus;
        diff = dst - cur;
        plus = (diff == 1) ||
               (diff == 1 - n) ||                      // wrap from last node to first
               ((cur == n - 4) && (dst == n - 2)) ||
               ((cur >= n - 2) && (dst <= n - 4)) ||
               ((diff > 0) && (dst <= n - 3));
        if (diff == 0) begin
            return 3'b001;
        end
        return plus ? 3'b100 : 3'b010;
    endfunction

    logic [2:0] x_dir;
    logic [2:0] y_dir;

    // stage register
    logic                        valid_q;
    torus_route_pkg::route_alg_e alg_q;
    logic                        x_plus_q;
    logic                        x_min_q;
    logic                        same_x_q;
    logic                        y_plus_q;
    logic                        y_min_q;
    logic                        same_y_q;

    always_comb begin
        x_dir = torus_dir(int'(current_x), int'(dest_x), NX);
        y_dir = torus_dir(int'(current_y), int'(dest_y), NY);
    end

    // stage free when empty or being drained
    assign req_ready = !valid_q || dir.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (req_ready) begin
            valid_q <= req_valid; // occupancy
        end
    end

    always_ff @(posedge clk) begin
        if (req_ready) begin
            alg_q                          <= req_alg;
            {x_plus_q, x_min_q, same_x_q}  <= x_dir;
            {y_plus_q, y_min_q, same_y_q}  <= y_dir;
        end
    end

    assign dir.valid  = valid_q;
    assign dir.alg    = alg_q;
    assign dir.x_plus = x_plus_q;
    assign dir.x_min  = x_min_q;
    assign dir.y_plus = y_plus_q;
    assign dir.y_min  = y_min_q;
    assign dir.same_x = same_x_q;
    assign dir.same_y = same_y_q;

endmodule

`default_nettype wire

// File: source/torus_port_select.sv
`default_nettype none

module torus_port_select (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    route_dir_if.consumer               dir,
    output logic                        resp_valid,
    input  wire logic                   resp_ready,
    output torus_route_pkg::destport_t  resp_destport
);

    torus_route_pkg::port_set_t match_set; // every productive direction
    torus_route_pkg::port_set_t port_set;  // allowed by the algorithm
    torus_route_pkg::destport_t destport;
    logic                       two_dim;

    // result register
    logic                       valid_q;
    torus_route_pkg::destport_t destport_q;

    assign two_dim = !dir.same_x && !dir.same_y;

    always_comb begin
        match_set                              = '0;
        match_set[torus_route_pkg::PORT_EAST]  = dir.x_plus;
        match_set[torus_route_pkg::PORT_WEST]  = dir.x_min;
        match_set[torus_route_pkg::PORT_SOUTH] = dir.y_plus;
        match_set[torus_route_pkg::PORT_NORTH] = dir.y_min;
    end

    always_comb begin
        port_set = '0;
        if (dir.same_x && dir.same_y) begin
            port_set[torus_route_pkg::PORT_LOCAL] = 1'b1; // arrived
        end else begin
            case (dir.alg)
                torus_route_pkg::ALG_XY: begin
                    if (dir.x_plus) begin
                        port_set[torus_route_pkg::PORT_EAST] = 1'b1;
                    end else if (dir.x_min) begin
                        port_set[torus_route_pkg::PORT_WEST] = 1'b1;
                    end else if (dir.y_plus) begin
                        port_set[torus_route_pkg::PORT_SOUTH] = 1'b1;
                    end else begin
                        port_set[torus_route_pkg::PORT_NORTH] = 1'b1;
                    end
                end
                torus_route_pkg::ALG_WEST_FIRST: begin
                    if (dir.x_min) begin
                        port_set[torus_route_pkg::PORT_WEST] = 1'b1; // west hops go first
                    end else begin
                        port_set = match_set;
                    end
                end
                torus_route_pkg::ALG_NORTH_LAST: begin
                    port_set = match_set;
                    if (two_dim && dir.y_min) begin
                        port_set[torus_route_pkg::PORT_NORTH] = 1'b0; // north only at the end
                    end
                end
                torus_route_pkg::ALG_NEGATIVE_FIRST: begin
                    port_set = match_set;
                    if (two_dim && dir.x_min && dir.y_min) begin
                        port_set[torus_route_pkg::PORT_NORTH] = 1'b0;
                    end
                    // no east to south turn
                    if (two_dim && dir.x_plus && dir.y_plus) begin
                        port_set[torus_route_pkg::PORT_EAST] = 1'b0;
                    end
                end
                torus_route_pkg::ALG_DUATO: begin
                    port_set = match_set;
                end
                default: begin
                    port_set = '0; // unused opcode
                end
            endcase
        end
    end

    // {x, y, a, b}
    assign destport = {
        dir.x_plus,
        dir.y_plus,
        port_set[torus_route_pkg::PORT_EAST]  | port_set[torus_route_pkg::PORT_WEST],
        port_set[torus_route_pkg::PORT_NORTH] | port_set[torus_route_pkg::PORT_SOUTH]
    };

    assign dir.ready = !valid_q || resp_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (dir.ready) begin
            valid_q <= dir.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dir.ready) begin
            destport_q <= destport; // held while the sink stalls
        end
    end

    assign resp_valid    = valid_q;
    assign resp_destport = destport_q;

endmodule

`default_nettype wire

// File: source/torus_route_pkg.sv
`default_nettype none

package torus_route_pkg;

    // routing algorithm opcodes
    typedef enum logic [2:0] {
        ALG_XY             = 3'd0, // deterministic dimension order
        ALG_WEST_FIRST     = 3'd1,
        ALG_NORTH_LAST     = 3'd2,
        ALG_NEGATIVE_FIRST = 3'd3,
        ALG_DUATO          = 3'd4  // fully adaptive
    } route_alg_e;

    // router port indices
    typedef enum logic [2:0] {
        PORT_LOCAL = 3'd0,
        PORT_EAST  = 3'd1,
        PORT_NORTH = 3'd2,
        PORT_WEST  = 3'd3,
        PORT_SOUTH = 3'd4
    } port_e;

    localparam int PORT_NUM = 5;

    // one bit per port, indexed by port_e
    typedef logic [PORT_NUM-1:0] port_set_t;

    localparam int DESTPORT_W = 4;

    // encoded destination port {x, y, a, b}
    // x: x_plus, y: y_plus
    // a: east or west allowed, b: north or south allowed
    typedef logic [DESTPORT_W-1:0] destport_t;

endpackage

`default_nettype wire

// File: source/torus_route_unit.sv
`default_nettype none

module torus_route_unit #(
    parameter int NX = 4, // torus width
    parameter int NY = 4  // torus height
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,

    // request stream
    input  wire logic                        req_valid,
    output logic                             req_ready,
    input  wire torus_route_pkg::route_alg_e req_alg,
    input  wire logic [XW-1:0]               req_current_x,
    input  wire logic [YW-1:0]               req_current_y,
    input  wire logic [XW-1:0]               req_dest_x,
    input  wire logic [YW-1:0]               req_dest_y,

    // response stream
    output logic                             resp_valid,
    input  wire logic                        resp_ready,
    output torus_route_pkg::destport_t       resp_destport
);

    localparam int XW = (NX > 1) ? $clog2(NX) : 1;
    localparam int YW = (NY > 1) ? $clog2(NY) : 1;

    // stage 1 to stage 2
    route_dir_if dir_if ();

    // direction flags, one cycle
    torus_dir_compare #(
        .NX (NX),
        .NY (NY)
    ) u_dir_compare (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_alg   (req_alg),
        .current_x (req_current_x),
        .current_y (req_current_y),
        .dest_x    (req_dest_x),
        .dest_y    (req_dest_y),
        .dir       (dir_if.producer)
    );

    // port set and encoding, one cycle
    torus_port_select u_port_select (
        .clk           (clk),
        .rst_n         (rst_n),
        .dir           (dir_if.consumer),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_destport (resp_destport)
    );

endmodule

`default_nettype wire

// File: testbench/tb_torus_route.sv
`default_nettype none

module tb_torus_route;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NX        = 4;
    localparam int NY        = 4;
    localparam int MAX_TESTS = 64;
    localparam logic [23:0] END_MARK = 24'hffffff; // marks unused entries

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    logic                        req_ready;
    torus_route_pkg::route_alg_e req_alg;
    logic [1:0]                  req_current_x;
    logic [1:0]                  req_current_y;
    logic [1:0]                  req_dest_x;
    logic [1:0]                  req_dest_y;
    logic                        resp_valid;
    logic                        resp_ready;
    torus_route_pkg::destport_t  resp_destport;

    // one hex digit each of {alg, cur_x, cur_y, dst_x, dst_y, expected}
    logic [23:0] test_mem [0:MAX_TESTS-1];
    int          num_tests;
    int          drive_idx;
    int          timeout_limit = 100;
    int          cycle_count   = 0;
    int          accept_count  = 0;
    int          resp_count    = 0;
    int          mismatch_count = 0;
    int          other_count    = 0;
    logic        check_latency = 1'b0;
    logic        random_sink   = 1'b0;

    // scoreboard holds one entry per accepted request
    int exp_q[$];
    int idx_q[$];
    int cyc_q[$];

    torus_route_unit #(
        .NX (NX),
        .NY (NY)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .req_alg       (req_alg),
        .req_current_x (req_current_x),
        .req_current_y (req_current_y),
        .req_dest_x    (req_dest_x),
        .req_dest_y    (req_dest_y),
        .resp_valid    (resp_valid),
        .resp_ready    (resp_ready),
        .resp_destport (resp_destport)
    );

    always #4 clk = ~clk;

    task automatic check_reset_outputs();
        begin
            if (resp_valid !== 1'b0) begin
                mismatch_count++;
                $display("Mismatch at %0t: resp_valid is %b in reset, expected 0",
                         $time, resp_valid);
            end
            if (req_ready !== 1'b1) begin
                mismatch_count++;
                $display("Mismatch at %0t: req_ready is %b in reset, expected 1",
                         $time, req_ready);
            end
        end
    endtask

    // present one test and hold it until accepted
    task automatic send_test(input int idx);
        logic [23:0] word;
        begin
            word = test_mem[idx];
            #1;
            drive_idx     = idx;
            req_valid     = 1'b1;
            req_alg       = torus_route_pkg::route_alg_e'(word[22:20]);
            req_current_x = word[17:16];
            req_current_y = word[13:12];
            req_dest_x    = word[9:8];
            req_dest_y    = word[5:4];
            @(posedge clk);
            while (!req_ready) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic idle_cycles(input int n);
        begin
            if (n > 0) begin
                #1;
                req_valid = 1'b0;
                repeat (n) @(posedge clk);
            end
        end
    endtask

    task automatic stop_requests();
        begin
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic wait_for_drain();
        begin
            while (resp_count < accept_count) begin
                @(posedge clk);
            end
        end
    endtask

    task automatic print_counts();
        begin
            $display("errors: %0d mismatches, %0d other, %0d of %0d responses checked",
                     mismatch_count, other_count, resp_count, accept_count);
        end
    endtask

    task automatic check_response();
        int exp;
        int idx;
        int start;
        begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("response at %0t arrived with no request outstanding", $time);
            end else begin
                exp   = exp_q.pop_front();
                idx   = idx_q.pop_front();
                start = cyc_q.pop_front();
                resp_count++;
                if (resp_destport !== torus_route_pkg::destport_t'(exp)) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: test %0d destport %h, expected %h",
                             $time, idx, resp_destport, exp[3:0]);
                end
                if (check_latency && (cycle_count - start != 2)) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: test %0d latency %0d cycles, expected 2",
                             $time, idx, cycle_count - start);
                end
            end
        end
    endtask

    // handshake monitor sees pre-edge values
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst_n) begin
            if (resp_valid && resp_ready) begin
                check_response();
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(int'(test_mem[drive_idx][3:0]));
                idx_q.push_back(drive_idx);
                cyc_q.push_back(cycle_count);
                accept_count++;
            end
        end
    end

    // sink stalls about one cycle in four when random
    always @(posedge clk) begin
        #1;
        if (random_sink) begin
            resp_ready = ($urandom % 4) != 0;
        end else begin
            resp_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (cycle_count >= timeout_limit) begin
            $display("timeout after %0d cycles with %0d responses still missing",
                     cycle_count, accept_count - resp_count);
            print_counts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_alg       = torus_route_pkg::ALG_XY;
        req_current_x = '0;
        req_current_y = '0;
        req_dest_x    = '0;
        req_dest_y    = '0;
        resp_ready    = 1'b1;
        drive_idx     = 0;
        void'($urandom(32'hebb8));

        for (int i = 0; i < MAX_TESTS; i++) begin
            test_mem[i] = END_MARK;
        end
        $readmemh("testbench/torus_route_tests.txt", test_mem);
        num_tests = 0;
        while ((num_tests < MAX_TESTS) && (test_mem[num_tests] !== END_MARK)) begin
            num_tests++;
        end
        timeout_limit = 20 * num_tests + 100;
        if (num_tests == 0) begin
            other_count++;
            $display("no tests were read from the tests file");
        end

        repeat (16) begin
            @(posedge clk);
            check_reset_outputs();
        end
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        check_reset_outputs(); // still idle one cycle after release

        // back to back with the sink always ready
        check_latency = 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            send_test(i);
        end
        stop_requests();
        wait_for_drain();

        // random gaps against a stalling sink
        check_latency = 1'b0;
        random_sink   = 1'b1;
        for (int i = 0; i < num_tests; i++) begin
            send_test(i);
            idle_cycles($urandom % 3);
        end
        stop_requests();
        wait_for_drain();

        print_counts();
        if ((mismatch_count == 0) && (other_count == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/torus_route_tests.txt
// one test per line: alg, cur_x, cur_y, dst_x, dst_y, expected destport
// one hex digit each; alg 0 xy, 1 west-first, 2 north-last, 3 negative-first, 4 duato
011002
011012
011026
011032
011101
011110
011125
011131
01120A
01121A
01122E
01123A
011302
011312
011326
011332
11122F
11120B
111026
111002
21122F
21120A
211027
211002
31122D
31120B
311027
311002
41122F
41120B
411027
411003
43300F
40022F
42200F
400333
03101A
013105
42002F
10220F
